// ==== rtl/pbs_bridge_pkg.sv ====
// AXIS to PBS bridge shared definitions
// Widths, tuser field positions, beat and metadata structs,
// and the PBS output word with its header and raw views

package pbs_bridge_pkg;

    // Datapath widths
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int USER_W = 128;

    // Metadata fields in the first beat's tuser
    localparam int LEN_POS = 0;   // Byte length, 16 bits
    localparam int SRC_POS = 16;  // One-hot source port, 8 bits
    localparam int DST_POS = 24;  // Destination port, 8 bits

    // One buffered AXIS beat, 201 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [USER_W-1:0] user;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axis_beat_t;

    // Decoded frame metadata
    typedef struct packed {
        logic [7:0]  dst_port;
        logic [2:0]  src_index;
        logic [15:0] word_count;
        logic [15:0] byte_len;
    } frame_meta_t;

    // Module header word, MSB first
    typedef struct packed {
        logic [7:0]  dst_pad;     // Always zero
        logic [7:0]  dst_port;
        logic [15:0] word_count;
        logic [7:0]  src_pad;     // Always zero
        logic [7:0]  src_index;
        logic [15:0] byte_len;
    } pbs_header_t;

    // One PBS word seen either as a header or as raw data
    typedef union packed {
        pbs_header_t       header;
        logic [DATA_W-1:0] raw;
    } pbs_word_u;

    typedef enum logic [1:0] {
        KIND_HEADER = 2'd0,
        KIND_DATA   = 2'd1
    } word_kind_e;

endpackage

// ==== rtl/stream_fifo.sv ====
// Small fall-through FIFO for AXIS beats
// Head entry is visible with zero read latency; nearly_full
// is raised while at most one slot is left

`timescale 1ns/100ps

module stream_fifo import pbs_bridge_pkg::*; #(
    parameter int FIFO_DEPTH_BITS = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  axis_beat_t din,
    input  logic       rd_en,
    output axis_beat_t dout,
    output logic       empty,
    output logic       nearly_full
);

    localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

    axis_beat_t                 mem [DEPTH];
    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_DEPTH_BITS:0]   count;
    logic                       full;

    // Storage, no reset needed
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign dout        = mem[rd_ptr];  // Fall-through head
    assign empty       = (count == '0);
    assign full        = (count == (FIFO_DEPTH_BITS + 1)'(DEPTH));
    assign nearly_full = (count >= (FIFO_DEPTH_BITS + 1)'(DEPTH - 1));

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> !empty);

endmodule

// ==== rtl/meta_decode.sv ====
// Frame metadata decoder
// Pulls byte length, source and destination out of the head
// beat's tuser and derives the 64-bit word count

`timescale 1ns/100ps

module meta_decode import pbs_bridge_pkg::*; (
    input  axis_beat_t  head,
    output frame_meta_t meta
);

    logic [15:0] byte_len;
    logic [7:0]  src_onehot;
    logic [7:0]  dst_port;
    logic [2:0]  src_index;
    logic [16:0] len_round;

    assign byte_len   = head.user[LEN_POS +: 16];
    assign src_onehot = head.user[SRC_POS +: 8];
    assign dst_port   = head.user[DST_POS +: 8];

    // One-hot source byte to bit index
    always_comb begin
        src_index = 3'd0;
        if ($onehot(src_onehot)) begin
            for (int i = 0; i < 8; i++) begin
                if (src_onehot[i]) begin
                    src_index = 3'(i);
                end
            end
        end
        // Anything not one-hot stays at port 0
    end

    // Round up to whole 8-byte words
    assign len_round = {1'b0, byte_len} + 17'd7;  // Extra bit keeps the carry

    always_comb begin
        meta.dst_port   = dst_port;
        meta.src_index  = src_index;
        meta.word_count = {2'b00, len_round[16:3]};
        meta.byte_len   = byte_len;
    end

endmodule

// ==== rtl/frame_sequencer.sv ====
// Frame sequencer
// Two-state FSM that issues one module header per frame, then
// each buffered beat as a data word, popping the FIFO as it goes

`timescale 1ns/100ps

module frame_sequencer import pbs_bridge_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  axis_beat_t        head,
    input  logic              empty,
    input  frame_meta_t       meta,
    input  logic              pbs_rdy,
    output logic              pop,
    output logic              issue,
    output word_kind_e        kind,
    output pbs_word_u         word,
    output logic [STRB_W-1:0] strb,
    output logic              last
);

    localparam logic IN_HEADER = 1'b0;
    localparam logic IN_DATA   = 1'b1;

    logic state;
    logic state_next;

    // A word goes out whenever a beat is waiting and the sink is ready
    assign issue = !empty && pbs_rdy;
    assign pop   = issue && (state == IN_DATA);  // Header issue leaves the beat in place

    always_comb begin
        state_next = state;
        if (issue) begin
            if (state == IN_HEADER) begin
                state_next = IN_DATA;
            end else if (head.last) begin
                state_next = IN_HEADER;  // End of frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IN_HEADER;
        end else begin
            state <= state_next;
        end
    end

    // Word contents for the current state
    always_comb begin
        word = '0;
        if (state == IN_HEADER) begin
            kind                   = KIND_HEADER;
            word.header.dst_pad    = 8'h00;
            word.header.dst_port   = meta.dst_port;
            word.header.word_count = meta.word_count;
            word.header.src_pad    = 8'h00;
            word.header.src_index  = {5'b00000, meta.src_index};
            word.header.byte_len   = meta.byte_len;
        end else begin
            kind     = KIND_DATA;
            word.raw = head.data;
        end
    end

    assign strb = head.strb;
    assign last = head.last && (state == IN_DATA);

    // The beat behind a header stays at the head for its first data word
    a_header_holds_head: assert property (@(posedge clk) disable iff (reset)
        (issue && kind == KIND_HEADER) |=> (!empty && $stable(head)));

    // Only the last beat of a frame may carry a partial strobe
    a_mid_strb_full: assert property (@(posedge clk) disable iff (reset)
        (pop && !head.last) |-> (head.strb == '1));

endmodule

// ==== rtl/pbs_word_former.sv ====
// PBS output word former
// Reverses byte lanes of data words, builds the control byte
// and registers the PBS write interface

`timescale 1ns/100ps

module pbs_word_former import pbs_bridge_pkg::*; #(
    parameter logic [STRB_W-1:0] HEADER_CTRL = 8'hFF
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue,
    input  word_kind_e        kind,
    input  pbs_word_u         word,
    input  logic [STRB_W-1:0] strb,
    input  logic              last,
    output logic [DATA_W-1:0] pbs_data,
    output logic [STRB_W-1:0] pbs_ctrl,
    output logic              pbs_wr
);

    logic [DATA_W-1:0] swapped;
    logic [STRB_W-1:0] end_ctrl;
    logic [STRB_W-1:0] data_ctrl;

    // Output byte i takes input byte STRB_W-1-i
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            swapped[i*8 +: 8] = word.raw[(STRB_W-1-i)*8 +: 8];
        end
    end

    // n valid low bytes mark bit STRB_W-n, anything else gives zero
    always_comb begin
        end_ctrl = '0;
        for (int n = 1; n <= STRB_W; n++) begin
            if (strb == STRB_W'((1 << n) - 1)) begin
                end_ctrl = STRB_W'(1 << (STRB_W - n));
            end
        end
    end

    assign data_ctrl = last ? end_ctrl : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pbs_wr   <= 1'b0;
            pbs_data <= '0;
            pbs_ctrl <= '0;
        end else begin
            pbs_wr <= issue;
            if (issue) begin  // Hold last word otherwise
                pbs_data <= (kind == KIND_HEADER) ? word.raw : swapped;
                pbs_ctrl <= (kind == KIND_HEADER) ? HEADER_CTRL : data_ctrl;
            end
        end
    end

    a_last_strb_contiguous: assert property (@(posedge clk) disable iff (reset)
        (issue && kind == KIND_DATA && last) |-> (strb[0] && ((strb & (strb + 1'b1)) == '0)));

endmodule

// ==== rtl/axis_pbs_bridge.sv ====
// AXIS to PBS bridge top level
// Buffers AXIS beats, then emits a module header and the
// byte-reversed data words of each frame on the PBS bus

`timescale 1ns/100ps

module axis_pbs_bridge import pbs_bridge_pkg::*; #(
    parameter int                FIFO_DEPTH_BITS = 2,
    parameter logic [STRB_W-1:0] HEADER_CTRL     = 8'hFF
) (
    input  logic              clk,
    input  logic              reset,

    // AXIS slave
    input  logic [DATA_W-1:0] axis_tdata,
    input  logic [STRB_W-1:0] axis_tstrb,
    input  logic [USER_W-1:0] axis_tuser,
    input  logic              axis_tvalid,
    input  logic              axis_tlast,
    output logic              axis_tready,

    // PBS master
    output logic [DATA_W-1:0] pbs_data,
    output logic [STRB_W-1:0] pbs_ctrl,
    output logic              pbs_wr,
    input  logic              pbs_rdy
);

    axis_beat_t        in_beat;
    axis_beat_t        head;
    frame_meta_t       meta;
    pbs_word_u         word;
    word_kind_e        kind;
    logic              fifo_empty;
    logic              fifo_nearly_full;
    logic              pop;
    logic              issue;
    logic [STRB_W-1:0] strb;
    logic              last;

    assign in_beat = '{data: axis_tdata, user: axis_tuser, strb: axis_tstrb,
                       last: axis_tlast};

    assign axis_tready = !fifo_nearly_full;  // One slot spare for the beat in flight

    stream_fifo #(
        .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
    ) u_fifo (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (axis_tvalid && axis_tready),
        .din         (in_beat),
        .rd_en       (pop),
        .dout        (head),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    meta_decode u_decode (
        .head (head),
        .meta (meta)
    );

    frame_sequencer u_seq (
        .clk     (clk),
        .reset   (reset),
        .head    (head),
        .empty   (fifo_empty),
        .meta    (meta),
        .pbs_rdy (pbs_rdy),
        .pop     (pop),
        .issue   (issue),
        .kind    (kind),
        .word    (word),
        .strb    (strb),
        .last    (last)
    );

    pbs_word_former #(
        .HEADER_CTRL(HEADER_CTRL)
    ) u_former (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .kind     (kind),
        .word     (word),
        .strb     (strb),
        .last     (last),
        .pbs_data (pbs_data),
        .pbs_ctrl (pbs_ctrl),
        .pbs_wr   (pbs_wr)
    );

endmodule

// ==== dv/bridge_tb.sv ====
// Testbench for the AXIS to PBS bridge
// Sends random frames under random sink back-pressure and checks
// every PBS word against a reference model of header and data rules

`timescale 1ns/100ps

module bridge_tb import pbs_bridge_pkg::*; ();

    localparam int NUM_FRAMES     = 200;
    localparam int MAX_BYTES      = 64;
    localparam int MAX_WORDS      = MAX_BYTES / 8;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_BYTES / 8 + 1) * 8;
    localparam logic [7:0] HEADER_CTRL = 8'hFF;

    logic              clk;
    logic              reset;
    logic [DATA_W-1:0] axis_tdata;
    logic [STRB_W-1:0] axis_tstrb;
    logic [USER_W-1:0] axis_tuser;
    logic              axis_tvalid;
    logic              axis_tlast;
    logic              axis_tready;
    logic [DATA_W-1:0] pbs_data;
    logic [STRB_W-1:0] pbs_ctrl;
    logic              pbs_wr;
    logic              pbs_rdy;

    integer      seed = 32'hc016;
    integer      rdy_seed = 32'hc016 ^ 32'h5a5a;
    logic [71:0] exp_q [$];          // {ctrl, data} in output order
    logic        tready_dropped = 1'b0;

    axis_pbs_bridge #(
        .FIFO_DEPTH_BITS(2),
        .HEADER_CTRL    (HEADER_CTRL)
    ) uut (
        .clk(clk), .reset(reset),
        .axis_tdata(axis_tdata), .axis_tstrb(axis_tstrb), .axis_tuser(axis_tuser),
        .axis_tvalid(axis_tvalid), .axis_tlast(axis_tlast), .axis_tready(axis_tready),
        .pbs_data(pbs_data), .pbs_ctrl(pbs_ctrl), .pbs_wr(pbs_wr), .pbs_rdy(pbs_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("** Error: %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Header word first, then each beat byte-reversed with its end control
    function automatic void expected_words(input logic [DATA_W-1:0] beats [MAX_WORDS],
                                           input int nbytes, input int src,
                                           input logic [7:0] dst,
                                           output logic [71:0] words [MAX_WORDS+1]);
        int          nwords;
        int          nlast;
        logic [7:0]  ctrl;
        logic [63:0] rev;
        nwords = (nbytes + 7) / 8;
        nlast  = nbytes - 8 * (nwords - 1);
        for (int i = 0; i <= MAX_WORDS; i++) begin
            words[i] = '0;
        end
        words[0] = {HEADER_CTRL, 8'h00, dst, 16'(nwords), 8'h00, 8'(src), 16'(nbytes)};
        for (int k = 0; k < nwords; k++) begin
            rev  = {<<8{beats[k]}};
            ctrl = (k == nwords - 1) ? 8'(1 << (8 - nlast)) : 8'h00;
            words[k+1] = {ctrl, rev};
        end
    endfunction

    task automatic send_beat(input logic [63:0] data, input logic [7:0] strb,
                             input logic [USER_W-1:0] user, input logic last);
        if (($random(seed) & 7) == 0) begin  // Occasional idle cycle
            @(negedge clk);
            axis_tvalid = 1'b0;
        end
        @(negedge clk);
        axis_tdata  = data;
        axis_tstrb  = strb;
        axis_tuser  = user;
        axis_tlast  = last;
        axis_tvalid = 1'b1;
        while (!axis_tready) begin
            @(negedge clk);
        end
        @(posedge clk);  // Beat taken here
    endtask

    // Frame driver
    initial begin
        int                nbytes;
        int                nwords;
        int                src;
        logic [7:0]        dst;
        logic [7:0]        last_strb;
        logic [USER_W-1:0] user;
        logic [DATA_W-1:0] beats [MAX_WORDS];
        logic [71:0]       words [MAX_WORDS+1];
        reset       = 1'b1;
        axis_tdata  = '0;
        axis_tstrb  = '0;
        axis_tuser  = '0;
        axis_tvalid = 1'b0;
        axis_tlast  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("idle pbs_wr", 64'(0), 64'(pbs_wr));
        check_value("idle tready", 64'(1), 64'(axis_tready));
        for (int f = 0; f < NUM_FRAMES; f++) begin
            case (f)  // Edge lengths first, then random
                0: nbytes = 1;
                1: nbytes = 8;
                2: nbytes = 16;
                3: nbytes = MAX_BYTES;
                4: nbytes = 5;
                default: nbytes = 1 + ($unsigned($random(seed)) % MAX_BYTES);
            endcase
            nwords    = (nbytes + 7) / 8;
            last_strb = 8'((9'd1 << (nbytes - 8 * (nwords - 1))) - 9'd1);
            src       = $unsigned($random(seed)) % 8;
            dst       = 8'($random(seed));
            for (int k = 0; k < MAX_WORDS; k++) begin
                beats[k][63:32] = $random(seed);
                beats[k][31:0]  = $random(seed);
            end
            expected_words(beats, nbytes, src, dst, words);
            for (int k = 0; k <= nwords; k++) begin
                exp_q.push_back(words[k]);
            end
            user = '0;
            user[LEN_POS +: 16] = 16'(nbytes);
            user[SRC_POS +: 8]  = 8'(1 << src);
            user[DST_POS +: 8]  = dst;
            for (int k = 0; k < nwords; k++) begin
                send_beat(beats[k], (k == nwords - 1) ? last_strb : 8'hFF, user,
                          k == nwords - 1);
            end
        end
        @(negedge clk);
        axis_tvalid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);  // Catch stray writes
        if (!tready_dropped) begin
            fail_run("tready never dropped during the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // Random sink readiness with long stalls to fill the FIFO
    initial begin
        integer r;
        integer stall;
        pbs_rdy = 1'b0;
        stall   = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        forever begin
            @(negedge clk);
            r = $random(rdy_seed);
            if (stall > 0) begin
                pbs_rdy = 1'b0;
                stall   = stall - 1;
            end else if (r[5:0] == 6'd0) begin
                pbs_rdy = 1'b0;
                stall   = 12 + r[9:6];
            end else begin
                pbs_rdy = (r[7:6] != 2'b00);
            end
        end
    end

    // Checker sampling outputs mid-cycle
    initial begin
        logic [71:0] want;
        logic        rdy_at_edge;
        int          word_no;
        word_no = 0;
        forever begin
            @(posedge clk);
            rdy_at_edge = pbs_rdy;
            @(negedge clk);
            if (!reset) begin
                if (!axis_tready) begin
                    tready_dropped = 1'b1;
                end
                if (pbs_wr) begin
                    if (!rdy_at_edge) begin
                        fail_run("pbs_wr asserted after a cycle with pbs_rdy low");
                    end
                    if (exp_q.size() == 0) begin
                        fail_run("pbs_wr asserted with no word expected");
                    end
                    want = exp_q.pop_front();
                    check_value($sformatf("word %0d data", word_no), want[63:0], pbs_data);
                    check_value($sformatf("word %0d ctrl", word_no), 64'(want[71:64]),
                                64'(pbs_ctrl));
                    word_no++;
                end
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
        fail_run("Timeout, frames did not drain in time");
    end

endmodule

// ==== compile.f ====
rtl/pbs_bridge_pkg.sv
rtl/stream_fifo.sv
rtl/meta_decode.sv
rtl/frame_sequencer.sv
rtl/pbs_word_former.sv
rtl/axis_pbs_bridge.sv
dv/bridge_tb.sv

// ==== Makefile ====
# Verilator build and run for the AXIS to PBS bridge testbench

VERILATOR ?= verilator
TOP       ?= bridge_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^SIMULATION PASSED$$'

clean:
	rm -rf $(BUILD_DIR)
